// ==== compile.f ====
+incdir+include
logic/ym_pkg.sv
logic/ym_write_if.sv
logic/ym_bus_port.sv
logic/ym_global_regs.sv
logic/ym_slot_update.sv
logic/ym_busy_timer.sv
logic/ym_mmr.sv
bench/ym_mmr_properties.sv
bench/ym_mmr_tb.sv

// ==== Bender.yml ====
package:
  name: ym_mmr

sources:
  - include_dirs:
      - include
    files:
      - logic/ym_pkg.sv
      - logic/ym_write_if.sv
      - logic/ym_bus_port.sv
      - logic/ym_global_regs.sv
      - logic/ym_slot_update.sv
      - logic/ym_busy_timer.sv
      - logic/ym_mmr.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/ym_mmr_properties.sv
      - bench/ym_mmr_tb.sv

// ==== bench/ym_mmr_tb.sv ====
/*
 * Directed testbench for the FM chip host write port
 * Drives address and data writes, checks the register bank,
 * the slot update strobes and the busy length
 */
`timescale 1ns/100ps
`include "ym_defs.svh"

module ym_mmr_tb;

    localparam int NUM_TESTS = 6;

    logic clk;
    logic rst;
    logic cen;
    logic write;
    logic [1:0] addr;
    ym_pkg::ym_data_t din;
    logic busy;
    ym_pkg::ym_timer_a_t value_a;
    ym_pkg::ym_timer_b_t value_b;
    logic load_a;
    logic load_b;
    logic enable_irq_a;
    logic enable_irq_b;
    logic clr_flag_a;
    logic clr_flag_b;
    logic fast_timers;
    logic eg_stop;
    logic pg_stop;
    logic csm;
    logic effect;
    logic lfo_en;
    logic [2:0] lfo_freq;
    ym_pkg::ym_sample_t pcm;
    logic pcm_en;
    logic pcm_wr;
    logic keyon_up;
    ym_pkg::ym_data_t slot_data;
    ym_pkg::ym_ch_t slot_ch;
    ym_pkg::ym_op_t slot_op;
    ym_pkg::ym_ch_update_t ch_up;
    ym_pkg::ym_op_update_t op_up;

    integer seed;
    int errors;
    int assert_fails;

    ym_mmr UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Clock enable on every second cycle
    initial begin
        cen = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            cen = ~cen;
        end
    end

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("** FAIL **");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic write_addr(input logic part, input logic [7:0] reg_addr);
        @(posedge clk);
        #1;
        write = 1'b1;
        addr  = {part, 1'b0};
        din   = reg_addr;
        @(posedge clk);
        #1;
        write = 1'b0;
    endtask

    // Returns just after the data edge, outputs already updated
    task automatic write_data(input logic [7:0] value);
        @(posedge clk);
        #1;
        write = 1'b1;
        addr  = 2'b01;
        din   = value;
        @(posedge clk);
        #1;
        write = 1'b0;
    endtask

    task automatic write_reg(input logic part, input logic [7:0] reg_addr,
                             input logic [7:0] value);
        write_addr(part, reg_addr);
        write_data(value);
    endtask

    // Next edge that samples cen high
    task automatic wait_cen;
        do @(posedge clk); while (!cen);
        #1;
    endtask

    task automatic test_reset;
        check("reset flags", 0, {busy, pcm_en, pcm_wr, keyon_up, load_a, load_b,
                                 enable_irq_a, enable_irq_b, clr_flag_a, clr_flag_b,
                                 fast_timers, eg_stop, pg_stop, csm, effect});
        check("reset lfo", 0, {lfo_en, lfo_freq});
        check("reset strobes", 0, {ch_up, op_up});
        check("reset value_a", 0, value_a);
        check("reset value_b", 0, value_b);
        check("reset pcm", 0, pcm);
    endtask

    task automatic test_timers;
        logic [7:0] a_hi;
        logic [7:0] a_lo;
        logic [7:0] b;
        logic [7:0] mode;
        logic [7:0] ctrl_exp;
        int i;
        a_hi = $random(seed);
        a_lo = $random(seed);
        b    = $random(seed);
        write_reg(1'b0, `YM_REG_CLKA1, a_hi);
        write_reg(1'b0, `YM_REG_CLKA2, a_lo);
        write_reg(1'b0, `YM_REG_CLKB, b);
        check("timers value_a", {a_hi, a_lo[1:0]}, value_a);
        check("timers value_b", b, value_b);
        for (i = 0; i < 4; i++) begin
            mode = $random(seed);
            mode[7:6] = i[1:0];     // Walk all four modes
            write_reg(1'b0, `YM_REG_TIMER, mode);
            check("timers effect", mode[7:6] != 2'b00, effect);
            check("timers csm", mode[7:6] == 2'b10, csm);
            check("timers control", mode[5:0], {clr_flag_b, clr_flag_a, enable_irq_b,
                                                enable_irq_a, load_b, load_a});
            wait_cen;
            check("timers clear flags", 0, {clr_flag_b, clr_flag_a});
        end
        // Last mode with its clear flags already dropped
        ctrl_exp = {mode[7:6] != 2'b00, mode[7:6] == 2'b10, 2'b00, mode[3:0]};
        write_reg(1'b1, `YM_REG_CLKA1, ~a_hi);
        write_reg(1'b1, `YM_REG_CLKB, ~b);
        write_reg(1'b1, `YM_REG_TIMER, 8'hFF);
        check("timers part1 value_a", {a_hi, a_lo[1:0]}, value_a);
        check("timers part1 value_b", b, value_b);
        check("timers part1 control", ctrl_exp, {effect, csm, clr_flag_b, clr_flag_a,
                                                 enable_irq_b, enable_irq_a, load_b, load_a});
    endtask

    task automatic test_lfo_test;
        logic [7:0] d;
        d = $random(seed);
        write_reg(1'b0, `YM_REG_LFO, d);
        check("lfo enable and freq", d[3:0], {lfo_en, lfo_freq});
        d = $random(seed);
        write_reg(1'b0, `YM_REG_TEST, d);
        check("test bits", {d[5], d[3], d[2]}, {eg_stop, pg_stop, fast_timers});
    endtask

    task automatic test_dac;
        logic [7:0] d;
        ym_pkg::ym_sample_t exp_pcm;
        d = $random(seed);
        exp_pcm = ({1'b0, d ^ 8'h80} << 1) | 9'd1;  // Sign flipped, low bit set
        write_reg(1'b0, `YM_REG_PCM, d);
        check("dac sample", exp_pcm, pcm);
        check("dac strobe set", 1, pcm_wr);
        wait_cen;
        check("dac strobe cleared", 0, pcm_wr);
        write_reg(1'b1, `YM_REG_DACTEST, 8'h00);
        check("dac test bit low", {exp_pcm[8:1], 1'b0}, pcm);
        check("dac test no strobe", 0, pcm_wr);
        write_reg(1'b1, `YM_REG_DACTEST, 8'h08);
        check("dac test bit high", 1, pcm[0]);
        write_reg(1'b0, `YM_REG_PCM_EN, 8'h80);
        check("dac enable set", 1, pcm_en);
        write_reg(1'b0, `YM_REG_PCM_EN, 8'h7F);
        check("dac enable clear", 0, pcm_en);
    endtask

    // One address in both parts against its expected groups
    task automatic check_slot(input logic [7:0] r, input logic [2:0] exp_ch,
                              input logic [6:0] exp_op);
        logic [7:0] d;
        int p;
        for (p = 0; p < 2; p++) begin
            d = $random(seed);
            write_reg(p[0], r, d);
            check("slot ch_up", exp_ch, ch_up);
            check("slot op_up", exp_op, op_up);
            check("slot keyon_up", (r == `YM_REG_KON) && (p == 0), keyon_up);
            check("slot channel", {p[0], r[1:0]}, slot_ch);
            check("slot operator", r[3:2], slot_op);
            check("slot data", d, slot_data);
        end
    endtask

    task automatic test_slots;
        check_slot(8'h30, 3'b000, 7'b0000001);
        check_slot(8'h41, 3'b000, 7'b0000010);
        check_slot(8'h52, 3'b000, 7'b0000100);
        check_slot(8'h64, 3'b000, 7'b0001000);
        check_slot(8'h75, 3'b000, 7'b0010000);
        check_slot(8'h86, 3'b000, 7'b0100000);
        check_slot(8'h9A, 3'b000, 7'b1000000);
        check_slot(8'hA1, 3'b001, 7'b0000000);
        check_slot(8'hB2, 3'b010, 7'b0000000);
        check_slot(8'hB5, 3'b100, 7'b0000000);
        check_slot(8'h37, 3'b000, 7'b0000000);  // Low bits 3
        check_slot(8'h28, 3'b000, 7'b0000000);
        check_slot(8'hA8, 3'b000, 7'b0000000);
    endtask

    // Counts cen pulses until busy drops, bounded past the expected length
    task automatic measure_busy(input int limit, output int pulses);
        pulses = 0;
        while (busy && pulses < limit) begin
            @(posedge clk);
            if (cen)
                pulses++;
            #1;
        end
    endtask

    task automatic test_busy;
        int pulses;
        measure_busy(`YM_BUSY_CYCLES + 8, pulses);   // Let the earlier writes run out
        check("busy idle", 0, busy);
        write_reg(1'b0, 8'h30, 8'h5A);
        check("busy after write", 1, busy);
        measure_busy(`YM_BUSY_CYCLES + 8, pulses);
        check("busy length", `YM_BUSY_CYCLES, pulses);
        check("busy dropped", 0, busy);
        write_reg(1'b0, 8'h30, 8'hA5);
        measure_busy(10, pulses);
        check("busy before restart", 1, busy);
        write_reg(1'b0, 8'h40, 8'h3C);
        measure_busy(`YM_BUSY_CYCLES + 8, pulses);
        check("busy restart length", `YM_BUSY_CYCLES, pulses);
    endtask

    initial begin
        seed   = 26;
        errors = 0;
        rst    = 1'b1;
        write  = 1'b0;
        addr   = '0;
        din    = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset;
        test_timers;
        test_lfo_test;
        test_dac;
        test_slots;
        test_busy;

        assert_fails = UUT.props.fail_count;
        $display("Errors: %0d check, %0d assertion", errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== bench/ym_mmr_properties.sv ====
/*
 * Bound checks for the FM register write path
 * Strobe encoding of the slot decoder and the cause of busy
 */
`timescale 1ns/100ps

module ym_mmr_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  valid,
    input logic                  busy,
    input ym_pkg::ym_ch_update_t ch_up,
    input ym_pkg::ym_op_update_t op_up
);

    int fail_count = 0;   // Read by the testbench at the end

    op_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(op_up))
        else begin
            fail_count++;
            $error("op_up has more than one operator group set");
        end

    // Channel and operator groups exclude each other
    ch_op_exclusive: assert property (@(posedge clk) disable iff (rst) !(|ch_up && |op_up))
        else begin
            fail_count++;
            $error("ch_up and op_up are both set");
        end

    busy_cause: assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> $past(valid))
        else begin
            fail_count++;
            $error("busy rose without a data write in the previous cycle");
        end

endmodule

bind ym_mmr ym_mmr_properties props (
    .clk   (clk),
    .rst   (rst),
    .valid (wr_bus.valid),
    .busy  (busy),
    .ch_up (ch_up),
    .op_up (op_up)
);

// ==== logic/ym_mmr.sv ====
/*
 * FM chip host write port and register bank
 * Bus port feeds the global registers, the slot update decoder
 * and the busy timer over one write interface
 */
`timescale 1ns/100ps

module ym_mmr (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic                  write,
    input  logic [1:0]            addr,
    input  ym_pkg::ym_data_t      din,
    output logic                  busy,
    // Timers and modes
    output ym_pkg::ym_timer_a_t   value_a,
    output ym_pkg::ym_timer_b_t   value_b,
    output logic                  load_a,
    output logic                  load_b,
    output logic                  enable_irq_a,
    output logic                  enable_irq_b,
    output logic                  clr_flag_a,
    output logic                  clr_flag_b,
    output logic                  fast_timers,
    output logic                  eg_stop,
    output logic                  pg_stop,
    output logic                  csm,
    output logic                  effect,
    output logic                  lfo_en,
    output logic [2:0]            lfo_freq,
    // DAC
    output ym_pkg::ym_sample_t    pcm,
    output logic                  pcm_en,
    output logic                  pcm_wr,
    // Slot updates
    output ym_pkg::ym_data_t      slot_data,
    output ym_pkg::ym_ch_t        slot_ch,
    output ym_pkg::ym_op_t        slot_op,
    output logic                  keyon_up,
    output ym_pkg::ym_ch_update_t ch_up,
    output ym_pkg::ym_op_update_t op_up
);

    ym_write_if wr_bus ();

    ym_bus_port u_bus_port (
        .clk   (clk),
        .rst   (rst),
        .write (write),
        .addr  (addr),
        .din   (din),
        .wr    (wr_bus.source)
    );

    ym_global_regs u_global_regs (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .wr           (wr_bus.sink),
        .value_a      (value_a),
        .value_b      (value_b),
        .load_a       (load_a),
        .load_b       (load_b),
        .enable_irq_a (enable_irq_a),
        .enable_irq_b (enable_irq_b),
        .clr_flag_a   (clr_flag_a),
        .clr_flag_b   (clr_flag_b),
        .fast_timers  (fast_timers),
        .eg_stop      (eg_stop),
        .pg_stop      (pg_stop),
        .csm          (csm),
        .effect       (effect),
        .lfo_en       (lfo_en),
        .lfo_freq     (lfo_freq),
        .pcm          (pcm),
        .pcm_en       (pcm_en),
        .pcm_wr       (pcm_wr)
    );

    ym_slot_update u_slot_update (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr_bus.sink),
        .slot_data (slot_data),
        .slot_ch   (slot_ch),
        .slot_op   (slot_op),
        .keyon_up  (keyon_up),
        .ch_up     (ch_up),
        .op_up     (op_up)
    );

    ym_busy_timer u_busy_timer (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .wr   (wr_bus.sink),
        .busy (busy)
    );

endmodule

// ==== logic/ym_busy_timer.sv ====
/*
 * Busy timer
 * Holds busy for a fixed count of clock-enable pulses after each data write
 */
`timescale 1ns/100ps
`include "ym_defs.svh"

module ym_busy_timer (
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    ym_write_if.sink wr,
    output logic     busy
);

    logic       valid_q;
    logic [4:0] busy_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= 1'b0;
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else begin
            valid_q <= wr.valid;
            if (wr.valid && !valid_q) begin
                busy     <= 1'b1;   // New write restarts the count
                busy_cnt <= '0;
            end else if (cen && busy) begin
                if (busy_cnt == 5'(`YM_BUSY_CYCLES - 1))
                    busy <= 1'b0;
                busy_cnt <= busy_cnt + 5'd1;
            end
        end
    end

endmodule

// ==== logic/ym_slot_update.sv ====
/*
 * Operator and channel update decoder
 * Turns data writes into one-hot group strobes with the
 * target channel, operator and data byte held alongside
 */
`timescale 1ns/100ps
`include "ym_defs.svh"

module ym_slot_update (
    input  logic                  clk,
    input  logic                  rst,
    ym_write_if.sink              wr,
    output ym_pkg::ym_data_t      slot_data,
    output ym_pkg::ym_ch_t        slot_ch,
    output ym_pkg::ym_op_t        slot_op,
    output logic                  keyon_up,
    output ym_pkg::ym_ch_update_t ch_up,
    output ym_pkg::ym_op_update_t op_up
);

    ym_pkg::ym_ch_update_t next_ch_up;
    ym_pkg::ym_op_update_t next_op_up;

    // Low bits 3 never address a channel
    always_comb begin
        next_ch_up = '0;
        next_op_up = '0;
        if (wr.reg_sel[1:0] != 2'b11) begin
            case (wr.reg_sel[7:4])
                4'hA: begin
                    if (wr.reg_sel[3:2] == 2'b00)
                        next_ch_up[`YM_CH_FNUM_LO] = 1'b1;  // A0 to A2
                end
                4'hB: begin
                    if (wr.reg_sel[3:2] == 2'b00)
                        next_ch_up[`YM_CH_ALG] = 1'b1;
                    else if (wr.reg_sel[3:2] == 2'b01)
                        next_ch_up[`YM_CH_PMS] = 1'b1;      // B4 to B6
                end
                default: begin
                    if (wr.reg_sel[7:4] >= `YM_OP_NIBBLE_LO &&
                        wr.reg_sel[7:4] <= `YM_OP_NIBBLE_HI)
                        next_op_up = ym_pkg::ym_op_update_t'(1)
                                     << (wr.reg_sel[7:4] - `YM_OP_NIBBLE_LO);
                end
            endcase
        end
    end

    // Everything holds until the next data write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            keyon_up <= 1'b0;
            ch_up    <= '0;
            op_up    <= '0;
        end else if (wr.valid) begin
            keyon_up <= (wr.reg_sel == `YM_REG_KON) && !wr.part;
            ch_up    <= next_ch_up;
            op_up    <= next_op_up;
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (wr.valid) begin
            slot_data <= wr.data;
            slot_ch   <= {wr.part, wr.reg_sel[1:0]};
            slot_op   <= wr.reg_sel[3:2];   // Slot order S1 S3 S2 S4
        end
    end

endmodule

// ==== logic/ym_global_regs.sv ====
/*
 * Global register bank
 * Timers, LFO, test bits, CSM and effect modes, and the DAC sample.
 * Clear flags and the sample strobe are one-shots
 */
`timescale 1ns/100ps
`include "ym_defs.svh"

module ym_global_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    ym_write_if.sink            wr,
    output ym_pkg::ym_timer_a_t value_a,
    output ym_pkg::ym_timer_b_t value_b,
    output logic                load_a,
    output logic                load_b,
    output logic                enable_irq_a,
    output logic                enable_irq_b,
    output logic                clr_flag_a,
    output logic                clr_flag_b,
    output logic                fast_timers,
    output logic                eg_stop,
    output logic                pg_stop,
    output logic                csm,
    output logic                effect,
    output logic                lfo_en,
    output logic [2:0]          lfo_freq,
    output ym_pkg::ym_sample_t  pcm,
    output logic                pcm_en,
    output logic                pcm_wr
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            value_a      <= '0;
            value_b      <= '0;
            load_a       <= 1'b0;
            load_b       <= 1'b0;
            enable_irq_a <= 1'b0;
            enable_irq_b <= 1'b0;
            clr_flag_a   <= 1'b0;
            clr_flag_b   <= 1'b0;
            fast_timers  <= 1'b0;
            eg_stop      <= 1'b0;
            pg_stop      <= 1'b0;
            csm          <= 1'b0;
            effect       <= 1'b0;
            lfo_en       <= 1'b0;
            lfo_freq     <= '0;
            pcm          <= '0;
            pcm_en       <= 1'b0;
            pcm_wr       <= 1'b0;
        end else if (wr.valid) begin
            if (!wr.part) begin
                case (wr.reg_sel)
                    `YM_REG_TEST: begin
                        eg_stop     <= wr.data[`YM_TEST_EG_STOP];
                        pg_stop     <= wr.data[`YM_TEST_PG_STOP];
                        fast_timers <= wr.data[`YM_TEST_FAST];
                    end
                    `YM_REG_LFO:   {lfo_en, lfo_freq} <= wr.data[3:0];
                    `YM_REG_CLKA1: value_a[9:2] <= wr.data;
                    `YM_REG_CLKA2: value_a[1:0] <= wr.data[1:0];
                    `YM_REG_CLKB:  value_b <= wr.data;
                    `YM_REG_TIMER: begin
                        effect <= |wr.data[7:6];             // Any mode other than normal
                        csm    <= wr.data[7:6] == 2'b10;
                        {clr_flag_b, clr_flag_a, enable_irq_b, enable_irq_a,
                         load_b, load_a} <= wr.data[5:0];
                    end
                    default: ;
                endcase
            end

            // DAC path answers in both parts
            case (wr.reg_sel)
                `YM_REG_PCM:     pcm <= {~wr.data[7], wr.data[6:0], 1'b1};  // Offset binary
                `YM_REG_DACTEST: pcm[0] <= wr.data[`YM_DACTEST_BIT];
                `YM_REG_PCM_EN:  pcm_en <= wr.data[`YM_PCM_EN_BIT];
                default: ;
            endcase
            pcm_wr <= wr.reg_sel == `YM_REG_PCM;
        end else if (cen) begin
            // One-shots drop on the first idle enable
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            pcm_wr     <= 1'b0;
        end
    end

endmodule

// ==== logic/ym_bus_port.sv ====
/*
 * Host bus port
 * Address writes select a register and part, data writes
 * go out on the write interface with the held selection
 */
`timescale 1ns/100ps

module ym_bus_port (
    input  logic             clk,
    input  logic             rst,
    input  logic             write,
    input  logic [1:0]       addr,
    input  ym_pkg::ym_data_t din,
    ym_write_if.source       wr
);

    ym_pkg::ym_reg_t sel_reg;
    logic            sel_part;

    // Address phase when A0 is low
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_reg  <= '0;
            sel_part <= 1'b0;
        end else if (write && !addr[0]) begin
            sel_reg  <= din;
            sel_part <= addr[1];  // A1 picks the upper part
        end
    end

    // Data phase is passed straight through
    assign wr.valid   = write & addr[0];
    assign wr.part    = sel_part;
    assign wr.reg_sel = sel_reg;
    assign wr.data    = din;

endmodule

// ==== logic/ym_write_if.sv ====
/*
 * One decoded host data write
 * Carries the held register address and part with the live data byte
 */
`timescale 1ns/100ps

interface ym_write_if;

    logic              valid;   // Data write in this cycle
    logic              part;    // Upper register part
    ym_pkg::ym_reg_t   reg_sel;
    ym_pkg::ym_data_t  data;

    modport source (
        output valid,
        output part,
        output reg_sel,
        output data
    );

    modport sink (
        input valid,
        input part,
        input reg_sel,
        input data
    );

endinterface

// ==== logic/ym_pkg.sv ====
/*
 * Shared types of the FM register write path
 * Address and data bytes, channel and operator selects,
 * timer reload values, DAC sample and update strobes
 */
package ym_pkg;

    typedef logic [7:0] ym_reg_t;   // Register address
    typedef logic [7:0] ym_data_t;  // Data byte

    // Channel number, top bit is the part
    typedef logic [2:0] ym_ch_t;

    // Operator slot from address bits 3..2
    typedef logic [1:0] ym_op_t;

    // Timer reload values
    typedef logic [9:0] ym_timer_a_t;
    typedef logic [7:0] ym_timer_b_t;

    // DAC sample, 8 data bits plus the low test bit
    typedef logic [8:0] ym_sample_t;

    // One-hot operator group strobe
    // dt1, tl, ks_ar, amen_dr, sr, sl_rr, ssgeg from bit 0 up
    typedef logic [6:0] ym_op_update_t;

    // One-hot channel group strobe
    // fnum_lo, alg, pms from bit 0 up
    typedef logic [2:0] ym_ch_update_t;

endpackage

// ==== include/ym_defs.svh ====
/*
 * FM register write path constants
 * Global register addresses, busy length and the bit
 * positions of the fields decoded from data bytes
 */
`ifndef YM_DEFS_SVH
`define YM_DEFS_SVH

// Global registers, part 0 only unless noted
`define YM_REG_TEST     8'h21
`define YM_REG_LFO      8'h22
`define YM_REG_CLKA1    8'h24   // Timer A bits 9..2
`define YM_REG_CLKA2    8'h25   // Timer A bits 1..0
`define YM_REG_CLKB     8'h26
`define YM_REG_TIMER    8'h27
`define YM_REG_KON      8'h28
`define YM_REG_PCM      8'h2A   // DAC registers ignore the part bit
`define YM_REG_PCM_EN   8'h2B
`define YM_REG_DACTEST  8'h2C

// Busy length in clock-enable pulses
`define YM_BUSY_CYCLES  32

// Test register fields
`define YM_TEST_EG_STOP 5
`define YM_TEST_PG_STOP 3
`define YM_TEST_FAST    2

// DAC fields
`define YM_PCM_EN_BIT   7
`define YM_DACTEST_BIT  3

// Channel strobe positions
`define YM_CH_FNUM_LO   0
`define YM_CH_ALG       1
`define YM_CH_PMS       2

// Operator registers occupy high nibbles 3 to 9
`define YM_OP_NIBBLE_LO 4'h3
`define YM_OP_NIBBLE_HI 4'h9

`endif
